/* fsab_consts.svh */
`ifndef FSAB_CONSTS_SVH
`define FSAB_CONSTS_SVH

// Bus field widths
`define FSAB_ADDR_W 31 // Word address
`define FSAB_DATA_W 64 // One beat
`define FSAB_MASK_W 8 // One bit per data byte
`define FSAB_LEN_W 3 // Burst length
`define FSAB_DID_W 4 // Device and subdevice tags
`define FSAB_MODE_W 3

// Mode codes
`define FSAB_MODE_READ 3'd0
`define FSAB_MODE_WRITE 3'd1

// Arbiter sizing
`define FSAB_DEVICES 4 // Requesters on the bus
`define FSAB_MEM_CREDITS 4 // Memory queue slots after reset
`define FSAB_CREDIT_W 3 // Counts 0 to FSAB_MEM_CREDITS

// Core reset sequencing
`define RST_STRETCH_CYCLES 16 // Hold after the cause clears
`define RST_SYNC_STAGES 3 // Button flops before use

// Board LEDs
`define LED_FLASH_CYCLES 5000000 // Long enough to see by eye
`define LED_HEARTBEAT_BITS 27 // Slow blink from cclk

`endif

/* fsab_pkg.sv */
package fsab_pkg;

`include "fsab_consts.svh"

	// Bus fields
	typedef logic [`FSAB_ADDR_W-1:0] fsab_addr_t; // Word address
	typedef logic [`FSAB_DATA_W-1:0] fsab_data_t;
	typedef logic [`FSAB_MASK_W-1:0] fsab_mask_t; // Byte enables
	typedef logic [`FSAB_LEN_W-1:0] fsab_len_t; // Beats in burst
	typedef logic [`FSAB_DID_W-1:0] fsab_did_t;
	typedef logic [`FSAB_MODE_W-1:0] fsab_mode_t; // FSAB_MODE_* codes

	// One request as it crosses the arbiter
	typedef struct packed {
		fsab_mode_t mode; // Read or write
		fsab_did_t did; // Issuing device
		fsab_did_t subdid; // Tag inside that device
		fsab_addr_t addr;
		fsab_len_t len;
		fsab_data_t data; // First write beat
		fsab_mask_t mask; // Byte enables for data
	} fsab_req_t;

	typedef logic [`FSAB_DEVICES-1:0] fsab_dev_mask_t; // One bit per requester

	typedef logic [4:0] led_t; // Board status LEDs

	// Core reset sequencer
	typedef enum logic [1:0] {
		RST_HOLD, // Cause or button active
		RST_STRETCH, // Counting toward release
		RST_RUN // Core out of reset
	} rst_state_t;

endpackage

/* reset_sequencer.sv */
`include "fsab_consts.svh"

module reset_sequencer (
	input logic cclk,
	input logic cclk_rst_cause_b,
	input logic corerst_btn, // Raw board button, active high
	output logic core_rst_b
);

	localparam int CNT_W = $clog2(`RST_STRETCH_CYCLES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RST_STRETCH_CYCLES - 1);

	logic [`RST_SYNC_STAGES-1:0] btn_sync_q; // Synchronizer chain
	logic btn_sync; // Button in cclk domain
	fsab_pkg::rst_state_t state_q;
	fsab_pkg::rst_state_t state_d;
	logic [CNT_W-1:0] cnt_q; // Stretch counter
	logic [CNT_W-1:0] cnt_d;
	logic core_rst_q; // Release flop

	assign btn_sync = btn_sync_q[`RST_SYNC_STAGES-1]; // Last stage only
	assign core_rst_b = core_rst_q;

	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b)
			btn_sync_q <= '0;
		else
			btn_sync_q <= {btn_sync_q[`RST_SYNC_STAGES-2:0], corerst_btn}; // Shift in button
	end

	always_comb begin
		state_d = state_q;
		cnt_d = cnt_q;
		case (state_q)
			fsab_pkg::RST_HOLD: begin
				cnt_d = '0; // Every release starts a full stretch
				if (!btn_sync)
					state_d = fsab_pkg::RST_STRETCH;
			end
			fsab_pkg::RST_STRETCH: begin
				cnt_d = cnt_q + 1'b1;
				if (btn_sync)
					state_d = fsab_pkg::RST_HOLD; // Pressed again, start over
				else if (cnt_q == CNT_LAST)
					state_d = fsab_pkg::RST_RUN;
			end
			fsab_pkg::RST_RUN: begin
				if (btn_sync)
					state_d = fsab_pkg::RST_HOLD;
			end
			default: state_d = fsab_pkg::RST_HOLD;
		endcase
	end

	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b) begin
			state_q <= fsab_pkg::RST_HOLD;
			cnt_q <= '0;
			core_rst_q <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q <= cnt_d;
			core_rst_q <= (state_d == fsab_pkg::RST_RUN); // Glitch-free release
		end
	end

	// Core never leaves reset while the synchronized button is held
	a_release_btn_idle: assert property (@(posedge cclk) disable iff (!cclk_rst_cause_b)
		$rose(core_rst_b) |-> !btn_sync);

endmodule

/* fsab_arbiter.sv */
`include "fsab_consts.svh"

module fsab_arbiter #(
	parameter int DEVICES = `FSAB_DEVICES
) (
	input logic cclk,
	input logic cclk_rst_cause_b,
	input fsab_pkg::fsab_dev_mask_t req_valid, // Level, held until granted
	input fsab_pkg::fsab_req_t [DEVICES-1:0] req, // One request per requester
	input logic mem_credit, // Pulse, memory freed one slot
	output fsab_pkg::fsab_dev_mask_t grant, // Same-cycle grant
	output logic fsabo_valid, // Pulse, fsabo holds an issue
	output fsab_pkg::fsab_req_t fsabo,
	output logic credit_avail // Memory can take a request
);

	typedef logic [`FSAB_CREDIT_W-1:0] credit_t;

	localparam credit_t CREDIT_MAX = credit_t'(`FSAB_MEM_CREDITS);

	credit_t credit_q; // Free memory slots
	logic issue; // A grant ends this cycle
	fsab_pkg::fsab_req_t issue_req; // Request of the granted requester

	assign credit_avail = (credit_q != '0);

	// Lowest valid index wins, nothing while memory is full
	assign grant = credit_avail ? (req_valid & (~req_valid + 1'b1)) : '0;
	assign issue = |grant;

	// One-hot mux onto the outgoing request
	always_comb begin
		issue_req = '0;
		for (int i = 0; i < DEVICES; i++) begin
			if (grant[i])
				issue_req = req[i];
		end
	end

	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b)
			fsabo_valid <= 1'b0;
		else
			fsabo_valid <= issue; // One cycle after the grant
	end

	// Payload only moves on an issue
	always_ff @(posedge cclk) begin
		if (issue)
			fsabo <= issue_req;
	end

	// Memory credit counter
	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b) begin
			credit_q <= CREDIT_MAX; // Memory starts empty
		end else begin
			case ({issue, mem_credit})
				2'b10: credit_q <= credit_q - 1'b1; // Issue takes a slot
				2'b01: credit_q <= credit_q + 1'b1; // Return frees one
				default: credit_q <= credit_q; // Both or neither
			endcase
		end
	end

	// At most one requester owns the cycle
	a_grant_onehot: assert property (@(posedge cclk) disable iff (!cclk_rst_cause_b)
		$onehot0(grant));

	// Memory never returns more than it handed out
	a_credit_bound: assert property (@(posedge cclk) disable iff (!cclk_rst_cause_b)
		credit_q <= CREDIT_MAX);

	// Full memory holds every requester off
	a_no_grant_dry: assert property (@(posedge cclk) disable iff (!cclk_rst_cause_b)
		(credit_q == '0) |-> (grant == '0));

endmodule

/* status_leds.sv */
`include "fsab_consts.svh"

module status_leds #(
	parameter int FLASH_CYCLES = `LED_FLASH_CYCLES
) (
	input logic cclk,
	input logic cclk_rst_cause_b,
	input logic core_rst_b, // From the reset sequencer
	input logic fsabo_valid, // Issue strobe from the arbiter
	input fsab_pkg::fsab_mode_t fsabo_mode,
	input logic credit_avail,
	output fsab_pkg::led_t leds
);

	localparam int FLASH_W = $clog2(FLASH_CYCLES + 1);
	localparam logic [FLASH_W-1:0] FLASH_LAST = FLASH_W'(FLASH_CYCLES - 1);

	logic read_seen; // Read forwarded to memory
	logic core_q;
	logic sticky_q; // Any read since reset
	logic flash_q; // Recent read
	logic credit_q;
	logic [FLASH_W-1:0] flash_cnt; // Cycles left in flash
	logic [`LED_HEARTBEAT_BITS-1:0] beat_cnt; // Free-running divider

	assign read_seen = fsabo_valid && (fsabo_mode == `FSAB_MODE_READ); // Writes ignored

	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b) begin
			core_q <= 1'b0;
			sticky_q <= 1'b0;
			credit_q <= 1'b1; // Memory starts with credits
			beat_cnt <= '0;
		end else begin
			core_q <= core_rst_b;
			credit_q <= credit_avail;
			beat_cnt <= beat_cnt + 1'b1;
			if (read_seen)
				sticky_q <= 1'b1; // Stays until reset
		end
	end

	// Read flash, each read reloads the full length
	always_ff @(posedge cclk or negedge cclk_rst_cause_b) begin
		if (!cclk_rst_cause_b) begin
			flash_q <= 1'b0;
			flash_cnt <= '0;
		end else if (read_seen) begin
			flash_q <= 1'b1;
			flash_cnt <= FLASH_LAST;
		end else if (flash_cnt != '0) begin
			flash_cnt <= flash_cnt - 1'b1;
		end else begin
			flash_q <= 1'b0; // Expired
		end
	end

	// Every bit straight from a flop
	assign leds = {
		core_q, // Bit 4, core out of reset
		sticky_q, // Bit 3, read seen
		flash_q, // Bit 2, read flash
		beat_cnt[`LED_HEARTBEAT_BITS-1], // Bit 1, heartbeat
		credit_q // Bit 0, credits left
	};

endmodule

/* system_glue.sv */
`include "fsab_consts.svh"

module system_glue #(
	parameter int FLASH_CYCLES = `LED_FLASH_CYCLES
) (
	input logic cclk,
	input logic cclk_rst_cause_b, // Board-level reset cause, active low
	input logic corerst_btn, // Core reset button, active high
	input fsab_pkg::fsab_dev_mask_t req_valid,
	input fsab_pkg::fsab_req_t [`FSAB_DEVICES-1:0] req,
	input logic mem_credit, // Credit return from memory
	output fsab_pkg::fsab_dev_mask_t grant,
	output logic fsabo_valid,
	output fsab_pkg::fsab_req_t fsabo, // Merged stream toward memory
	output logic core_rst_b,
	output fsab_pkg::led_t leds
);

	logic credit_avail; // Arbiter to LEDs

	reset_sequencer u_rst (
		.cclk (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b),
		.corerst_btn (corerst_btn),
		.core_rst_b (core_rst_b)
	);

	fsab_arbiter #(
		.DEVICES (`FSAB_DEVICES)
	) u_arb (
		.cclk (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b), // Runs beside the core reset
		.req_valid (req_valid),
		.req (req),
		.mem_credit (mem_credit),
		.grant (grant),
		.fsabo_valid (fsabo_valid),
		.fsabo (fsabo),
		.credit_avail (credit_avail)
	);

	status_leds #(
		.FLASH_CYCLES (FLASH_CYCLES)
	) u_leds (
		.cclk (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b),
		.core_rst_b (core_rst_b),
		.fsabo_valid (fsabo_valid),
		.fsabo_mode (fsabo.mode), // Only the mode matters here
		.credit_avail (credit_avail),
		.leds (leds)
	);

endmodule

/* tb_clock.sv */
module tb_clock (
	output logic cclk,
	output logic rst_b // Drives cclk_rst_cause_b
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		cclk = 1'b0;
		forever #4 cclk = ~cclk; // 8 ns period
	end

	initial begin
		rst_b = 1'b0;
		repeat (16) @(posedge cclk); // Sixteen edges in reset
		@(negedge cclk);
		rst_b = 1'b1; // Release away from the rising edge
	end

endmodule

/* tb_system_glue.sv */
`include "fsab_consts.svh"

module tb_system_glue;

	timeunit 1ns;
	timeprecision 1ps;

	// One trace line, held for cnt cycles
	typedef struct packed {
		logic [7:0] cnt;
		fsab_pkg::fsab_dev_mask_t valid;
		logic [3:0] chg; // Requester whose request changes, F for none
		fsab_pkg::fsab_mode_t mode;
		fsab_pkg::fsab_addr_t addr;
		logic credit;
		logic btn;
		fsab_pkg::fsab_dev_mask_t egrant;
		logic efv;
		logic [3:0] edev; // Requester expected on fsabo
		logic erst;
		fsab_pkg::led_t eleds;
	} trace_line_t;

	trace_line_t lines[$];
	int total_cycles;
	logic trace_ready;
	logic trace_ok;

	logic cclk;
	logic cclk_rst_cause_b;
	logic corerst_btn;
	fsab_pkg::fsab_dev_mask_t req_valid;
	fsab_pkg::fsab_req_t [`FSAB_DEVICES-1:0] req;
	logic mem_credit;
	fsab_pkg::fsab_dev_mask_t grant;
	logic fsabo_valid;
	fsab_pkg::fsab_req_t fsabo;
	logic core_rst_b;
	fsab_pkg::led_t leds;

	tb_clock u_clk (
		.cclk (cclk),
		.rst_b (cclk_rst_cause_b)
	);

	system_glue #(
		.FLASH_CYCLES (40) // Short flash for simulation
	) u_dut (
		.cclk (cclk),
		.cclk_rst_cause_b (cclk_rst_cause_b),
		.corerst_btn (corerst_btn),
		.req_valid (req_valid),
		.req (req),
		.mem_credit (mem_credit),
		.grant (grant),
		.fsabo_valid (fsabo_valid),
		.fsabo (fsabo),
		.core_rst_b (core_rst_b),
		.leds (leds)
	);

	task automatic abort_run;
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_grant(input fsab_pkg::fsab_dev_mask_t got,
		input fsab_pkg::fsab_dev_mask_t exp);
		if (got !== exp) begin
			$display("Fail grant: got %h expected %h at %0t", got, exp, $time);
			abort_run();
		end
	endtask

	task automatic check_req(input fsab_pkg::fsab_req_t got, input fsab_pkg::fsab_req_t exp);
		if (got !== exp) begin
			$display("Fail fsabo: got %h expected %h at %0t", got, exp, $time);
			abort_run();
		end
	endtask

	task automatic check_leds(input fsab_pkg::led_t got, input fsab_pkg::led_t exp);
		if (got !== exp) begin
			$display("Fail leds: got %h expected %h at %0t", got, exp, $time);
			abort_run();
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
			abort_run();
		end
	endtask

	// Whole trace into the queue before the run starts
	task automatic read_trace(output logic ok);
		int fd;
		int rc;
		string text;
		int c, v, ch, m, a, cr, b, eg, ef, ed, er, el;
		trace_line_t t;
		ok = 1'b1;
		fd = $fopen("system_glue_trace.txt", "r");
		if (fd == 0) begin
			ok = 1'b0; // No file
		end else begin
			while ($fgets(text, fd) > 0) begin
				rc = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h",
					c, v, ch, m, a, cr, b, eg, ef, ed, er, el);
				if (rc == 12) begin
					t.cnt = 8'(c);
					t.valid = fsab_pkg::fsab_dev_mask_t'(v);
					t.chg = 4'(ch);
					t.mode = fsab_pkg::fsab_mode_t'(m);
					t.addr = fsab_pkg::fsab_addr_t'(a);
					t.credit = cr[0];
					t.btn = b[0];
					t.egrant = fsab_pkg::fsab_dev_mask_t'(eg);
					t.efv = ef[0];
					t.edev = 4'(ed);
					t.erst = er[0];
					t.eleds = fsab_pkg::led_t'(el);
					lines.push_back(t);
				end else if (rc > 0) begin
					ok = 1'b0; // Partial line
				end
			end
			$fclose(fd);
		end
	endtask

	// Drive one line per falling edge, check mid low phase
	task automatic run_line(input trace_line_t t);
		fsab_pkg::fsab_req_t [`FSAB_DEVICES-1:0] prev; // Requests of the cycle before
		fsab_pkg::fsab_req_t nreq;
		int n;
		for (n = 0; n < int'(t.cnt); n++) begin
			@(negedge cclk);
			prev = req;
			req_valid = t.valid;
			mem_credit = t.credit;
			corerst_btn = t.btn;
			if (n == 0 && t.chg < `FSAB_DEVICES) begin
				nreq.mode = t.mode;
				nreq.did = t.chg;
				nreq.subdid = fsab_pkg::fsab_did_t'($urandom);
				nreq.addr = t.addr;
				nreq.len = fsab_pkg::fsab_len_t'($urandom);
				nreq.data = {$urandom, $urandom}; // Random payload
				nreq.mask = fsab_pkg::fsab_mask_t'($urandom);
				req[t.chg] = nreq;
			end
			#2;
			check_grant(grant, t.egrant);
			check_level("fsabo_valid", fsabo_valid, t.efv);
			check_level("core_rst_b", core_rst_b, t.erst);
			check_leds(leds, t.eleds);
			if (t.efv)
				check_req(fsabo, prev[t.edev]); // Granted one cycle back
		end
	endtask

	initial begin
		req_valid = '0;
		req = '0;
		mem_credit = 1'b0;
		corerst_btn = 1'b0;
		trace_ready = 1'b0;
		total_cycles = 0;
		void'($urandom(23));
		read_trace(trace_ok);
		if (!trace_ok) begin
			$display("Trace file system_glue_trace.txt is missing or has a broken line");
			abort_run();
		end else begin
			foreach (lines[i])
				total_cycles += int'(lines[i].cnt);
			trace_ready = 1'b1;
			foreach (lines[i])
				run_line(lines[i]);
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

	// Watchdog, trace length plus margin
	initial begin
		wait (trace_ready);
		repeat (total_cycles + 64) @(posedge cclk);
		$display("Watchdog expired before the trace finished");
		abort_run();
	end

endmodule

/* system_glue_trace.txt */
# cnt valid chg mode addr credit btn | exp: grant fsabo_valid dev core_rst_b leds
# All hex, chg F means no request changes, dev is the requester expected on fsabo
20 0 f 0 0   0 0  0 0 0 0 01
1  0 f 0 0   0 0  0 0 0 1 01
1  0 f 0 0   0 0  0 0 0 1 11
1  0 0 1 100 0 0  0 0 0 1 11
1  0 1 1 110 0 0  0 0 0 1 11
1  0 2 1 120 0 0  0 0 0 1 11
1  0 3 1 130 0 0  0 0 0 1 11
# Priority, lowest index first
1  e f 0 0   0 0  2 0 0 1 11
1  c f 0 0   0 0  4 1 1 1 11
1  9 f 0 0   0 0  1 1 2 1 11
1  8 f 0 0   0 0  8 1 0 1 11
# Credits drained
1  2 1 0 140 0 0  0 1 3 1 11
3  2 f 0 0   0 0  0 0 0 1 10
1  2 f 0 0   1 0  0 0 0 1 10
1  2 f 0 0   0 0  2 0 0 1 10
1  1 f 0 0   0 0  0 1 1 1 11
1  1 f 0 0   0 0  0 0 0 1 1c
1  1 f 0 0   1 0  0 0 0 1 1c
1  1 f 0 0   0 0  1 0 0 1 1c
1  0 f 0 0   0 0  0 1 0 1 1d
2  0 f 0 0   1 0  0 0 0 1 1c
2  0 f 0 0   1 0  0 0 0 1 1d
# Button held, then released
4  0 f 0 0   0 1  0 0 0 1 1d
1  0 f 0 0   0 1  0 0 0 0 1d
3  0 f 0 0   0 1  0 0 0 0 0d
4  0 f 0 0   0 0  0 0 0 0 0d
1  4 2 1 150 0 0  4 0 0 0 0d
1  8 3 1 160 0 0  8 1 2 0 0d
1  0 f 0 0   0 0  0 1 3 0 0d
d  0 f 0 0   0 0  0 0 0 0 0d
1  0 f 0 0   0 0  0 0 0 1 0d
3  0 f 0 0   0 0  0 0 0 1 1d
# Flash expired, write leaves the read bits alone
1  2 1 1 170 0 0  2 0 0 1 19
1  0 f 0 0   0 0  0 1 1 1 19
4  0 f 0 0   0 0  0 0 0 1 19

/* all.f */
+incdir+.
fsab_pkg.sv
reset_sequencer.sv
fsab_arbiter.sv
status_leds.sv
system_glue.sv
tb_clock.sv
tb_system_glue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_system_glue
FLIST     ?= all.f
FLAGS     ?= --timing --assert --timescale 1ns/1ps
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
